/* design/alu_operand_select.sv */
// ALU operand muxing

`timescale 1ns/1ps
`default_nettype none

module alu_operand_select import decode_pkg::*; (
    decode_if.consumer dec,
    input logic [XLEN-1:0] rs1_data,
    input logic [XLEN-1:0] rs2_data,
    output alu_payload_t operands
);

    logic [XLEN-1:0] upper_imm;
    logic [XLEN-1:0] arith_imm;

    assign upper_imm = {dec.instruction[31:12], 12'b0};
    assign arith_imm = {{(XLEN-12){dec.instruction[31]}}, dec.instruction[31:20]};

    // First operand
    always_comb begin
        case (dec.opcode)
            LUI_T: operands.op1 = '0;
            AUIPC_T, JAL_T, JALR_T: operands.op1 = dec.pc;
            default: operands.op1 = rs1_data;
        endcase
    end

    // Second operand, jumps add 4 to form the return address
    always_comb begin
        case (dec.opcode)
            LUI_T, AUIPC_T: operands.op2 = upper_imm;
            JAL_T, JALR_T: operands.op2 = XLEN'(4);
            ARITH_IMM_T: operands.op2 = arith_imm;
            default: operands.op2 = rs2_data;
        endcase
    end

endmodule

`default_nettype wire

/* design/decode_if.sv */
// Classified instruction bundle

`timescale 1ns/1ps
`default_nettype none

interface decode_if import decode_pkg::*; ();

    unit_vec_t unit_request;
    logic is_load;
    logic is_store;
    logic illegal;
    logic [2:0] fn3;
    opcode_t opcode;
    logic [XLEN-1:0] instruction;
    logic [XLEN-1:0] pc;

    modport producer (
        output unit_request, is_load, is_store, illegal,
        output fn3, opcode, instruction, pc
    );

    modport consumer (
        input unit_request, is_load, is_store, illegal,
        input fn3, opcode, instruction, pc
    );

endinterface

`default_nettype wire

/* design/decode_pkg.sv */
// Decode stage shared definitions

`default_nettype none

package decode_pkg;

    ////////////////////////////////////////
    // Widths and unit indices
    localparam int XLEN = 32;
    localparam int NUM_UNITS = 4;

    localparam int BRANCH_UNIT = 0;
    localparam int ALU_UNIT = 1;
    localparam int LS_UNIT = 2;
    localparam int GC_UNIT = 3;

    typedef logic [NUM_UNITS-1:0] unit_vec_t;

    ////////////////////////////////////////
    // Trimmed opcodes, instruction bits 6:2
    typedef logic [4:0] opcode_t;

    localparam opcode_t LUI_T = 5'b01101;
    localparam opcode_t AUIPC_T = 5'b00101;
    localparam opcode_t JAL_T = 5'b11011;
    localparam opcode_t JALR_T = 5'b11001;
    localparam opcode_t BRANCH_T = 5'b11000;
    localparam opcode_t LOAD_T = 5'b00000;
    localparam opcode_t STORE_T = 5'b01000;
    localparam opcode_t ARITH_T = 5'b01100;
    localparam opcode_t ARITH_IMM_T = 5'b00100;
    localparam opcode_t FENCE_T = 5'b00011;
    localparam opcode_t SYSTEM_T = 5'b11100;

    ////////////////////////////////////////
    // Unit payloads
    typedef struct packed {
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
    } alu_payload_t;

    typedef struct packed {
        logic [XLEN-1:0] address;
        logic [XLEN-1:0] store_data;
        logic [2:0] fn3;
        logic is_load;
        logic is_store;
        logic store_forward;
    } ls_payload_t;

endpackage

`default_nettype wire

/* design/decode_stage.sv */
// Decode and issue stage top

`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input logic clk,
    input logic rst,

    input logic fb_valid,
    input logic [XLEN-1:0] instruction,
    input logic [XLEN-1:0] pc,
    input logic [XLEN-1:0] rs1_data,
    input logic [XLEN-1:0] rs2_data,
    input logic rs1_conflict,
    input logic rs2_conflict,
    input unit_vec_t unit_ready,
    input logic issue_hold,

    output logic pop,
    output logic branch_issue,
    output logic gc_issue,
    output logic gc_illegal,

    output logic alu_valid,
    output logic [XLEN-1:0] alu_op1,
    output logic [XLEN-1:0] alu_op2,

    output logic ls_valid,
    output logic [XLEN-1:0] ls_address,
    output logic [XLEN-1:0] ls_store_data,
    output logic [2:0] ls_fn3,
    output logic ls_is_load,
    output logic ls_is_store,
    output logic ls_store_forward
);

    logic alu_load;
    logic ls_load;
    alu_payload_t alu_operands;
    alu_payload_t alu_payload;
    ls_payload_t ls_request;
    ls_payload_t ls_payload;

    decode_if dec ();

    ////////////////////////////////////////
    // Decode
    instruction_classifier classifier (
        .instruction(instruction),
        .pc(pc),
        .dec(dec.producer)
    );

    issue_control issue_ctrl (
        .clk(clk),
        .rst(rst),
        .dec(dec.consumer),
        .fb_valid(fb_valid),
        .issue_hold(issue_hold),
        .rs1_conflict(rs1_conflict),
        .rs2_conflict(rs2_conflict),
        .unit_ready(unit_ready),
        .pop(pop),
        .alu_load(alu_load),
        .ls_load(ls_load),
        .branch_issue(branch_issue),
        .gc_issue(gc_issue),
        .gc_illegal(gc_illegal)
    );

    alu_operand_select alu_select (
        .dec(dec.consumer),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .operands(alu_operands)
    );

    ls_address_gen ls_gen (
        .dec(dec.consumer),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rs2_conflict(rs2_conflict),
        .request(ls_request)
    );

    ////////////////////////////////////////
    // Unit registers
    issue_register #(.payload_t(alu_payload_t)) alu_reg (
        .clk(clk),
        .rst(rst),
        .load(alu_load),
        .payload_in(alu_operands),
        .valid(alu_valid),
        .payload_out(alu_payload)
    );

    issue_register #(.payload_t(ls_payload_t)) ls_reg (
        .clk(clk),
        .rst(rst),
        .load(ls_load),
        .payload_in(ls_request),
        .valid(ls_valid),
        .payload_out(ls_payload)
    );

    assign alu_op1 = alu_payload.op1;
    assign alu_op2 = alu_payload.op2;

    assign ls_address = ls_payload.address;
    assign ls_store_data = ls_payload.store_data;
    assign ls_fn3 = ls_payload.fn3;
    assign ls_is_load = ls_payload.is_load;
    assign ls_is_store = ls_payload.is_store;
    assign ls_store_forward = ls_payload.store_forward;

endmodule

`default_nettype wire

/* design/instruction_classifier.sv */
// Opcode classification and legality

`timescale 1ns/1ps
`default_nettype none

module instruction_classifier import decode_pkg::*; (
    input logic [XLEN-1:0] instruction,
    input logic [XLEN-1:0] pc,
    decode_if.producer dec
);

    opcode_t opcode;
    logic valid_opcode;
    logic mul_div_op;
    logic illegal;
    unit_vec_t base_request;

    assign opcode = instruction[6:2];

    ////////////////////////////////////////
    // Legality
    assign valid_opcode = (instruction[1:0] == 2'b11) &&
        (opcode inside {LUI_T, AUIPC_T, JAL_T, JALR_T, BRANCH_T, LOAD_T, STORE_T,
                        ARITH_T, ARITH_IMM_T, FENCE_T, SYSTEM_T});

    // No M extension, so funct7 bit 0 on a register op is illegal
    assign mul_div_op = (opcode == ARITH_T) && instruction[25];
    assign illegal = ~valid_opcode | mul_div_op;

    ////////////////////////////////////////
    // Unit requests
    always_comb begin
        base_request = '0;
        case (opcode)
            BRANCH_T: base_request[BRANCH_UNIT] = 1'b1;
            JAL_T, JALR_T: begin
                // Link value comes from the ALU
                base_request[BRANCH_UNIT] = 1'b1;
                base_request[ALU_UNIT] = 1'b1;
            end
            LUI_T, AUIPC_T, ARITH_T, ARITH_IMM_T: base_request[ALU_UNIT] = 1'b1;
            LOAD_T, STORE_T: base_request[LS_UNIT] = 1'b1;
            default: base_request[GC_UNIT] = 1'b1;
        endcase
    end

    // Illegal words go to GC alone, which raises the exception
    always_comb begin
        dec.unit_request = base_request;
        if (illegal) begin
            dec.unit_request = '0;
            dec.unit_request[GC_UNIT] = 1'b1;
        end
    end

    assign dec.is_load = (opcode == LOAD_T) & ~illegal;
    assign dec.is_store = (opcode == STORE_T) & ~illegal;
    assign dec.illegal = illegal;
    assign dec.fn3 = instruction[14:12];
    assign dec.opcode = opcode;
    assign dec.instruction = instruction;
    assign dec.pc = pc;

endmodule

`default_nettype wire

/* design/issue_control.sv */
// Issue decision and unit strobes

`timescale 1ns/1ps
`default_nettype none

module issue_control import decode_pkg::*; (
    input logic clk,
    input logic rst,
    decode_if.consumer dec,
    input logic fb_valid,
    input logic issue_hold,
    input logic rs1_conflict,
    input logic rs2_conflict,
    input unit_vec_t unit_ready,
    output logic pop,
    output logic alu_load,
    output logic ls_load,
    output logic branch_issue,
    output logic gc_issue,
    output logic gc_illegal
);

    logic operands_ready;
    logic units_ready;
    logic jump;
    unit_vec_t issue;
    unit_vec_t issue_r;

    ////////////////////////////////////////
    // Issue rule
    // Stores forward rs2 inside the LS unit
    assign operands_ready = ~rs1_conflict & (~rs2_conflict | dec.is_store);
    assign units_ready = ((dec.unit_request & ~unit_ready) == '0);

    assign pop = fb_valid & ~issue_hold & operands_ready & units_ready;
    assign issue = dec.unit_request & {NUM_UNITS{pop}};

    assign alu_load = issue[ALU_UNIT];
    assign ls_load = issue[LS_UNIT];
    assign jump = dec.opcode inside {JAL_T, JALR_T};

    ////////////////////////////////////////
    // Registered pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_r <= '0;
            gc_illegal <= 1'b0;
        end else begin
            issue_r <= issue;
            gc_illegal <= issue[GC_UNIT] & dec.illegal;
        end
    end

    assign branch_issue = issue_r[BRANCH_UNIT];
    assign gc_issue = issue_r[GC_UNIT];

    // Only jumps fan out to more than one unit
    multi_unit_only_jump: assert property (@(posedge clk) disable iff (rst)
        !$onehot0(issue_r) |-> $past(pop && jump));

    // Every issued word goes to at least one unit
    issue_has_unit: assert property (@(posedge clk) disable iff (rst)
        pop |-> (dec.unit_request != '0));

endmodule

`default_nettype wire

/* design/issue_register.sv */
// Unit payload register

`timescale 1ns/1ps
`default_nettype none

module issue_register #(
    parameter type payload_t = logic [31:0]
) (
    input logic clk,
    input logic rst,
    input logic load,
    input payload_t payload_in,
    output logic valid,
    output payload_t payload_out
);

    always_ff @(posedge clk) begin
        if (rst)
            valid <= 1'b0;
        else
            valid <= load;
    end

    // Payload holds between issues
    always_ff @(posedge clk) begin
        if (load)
            payload_out <= payload_in;
    end

    // A unit never sees an undefined payload
    payload_known_when_valid: assert property (@(posedge clk) disable iff (rst)
        valid |-> !$isunknown(payload_out));

endmodule

`default_nettype wire

/* design/ls_address_gen.sv */
// Load-store request build

`timescale 1ns/1ps
`default_nettype none

module ls_address_gen import decode_pkg::*; (
    decode_if.consumer dec,
    input logic [XLEN-1:0] rs1_data,
    input logic [XLEN-1:0] rs2_data,
    input logic rs2_conflict,
    output ls_payload_t request
);

    logic [11:0] offset;

    // S-type splits the immediate around rd
    assign offset = dec.is_store ?
        {dec.instruction[31:25], dec.instruction[11:7]} : dec.instruction[31:20];

    assign request.address = rs1_data + {{(XLEN-12){offset[11]}}, offset};
    assign request.store_data = rs2_data;
    assign request.fn3 = dec.fn3;
    assign request.is_load = dec.is_load;
    assign request.is_store = dec.is_store;

    // Store data still in flight, LS unit picks it up later
    assign request.store_forward = dec.is_store & rs2_conflict;

endmodule

`default_nettype wire

/* files.f */
design/decode_pkg.sv
design/decode_if.sv
design/instruction_classifier.sv
design/issue_control.sv
design/alu_operand_select.sv
design/ls_address_gen.sv
design/issue_register.sv
design/decode_stage.sv
testbench/decode_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module decode_tb \
    -f files.f -o decode_sim \
    && ./obj_dir/decode_sim | tee /dev/stderr | grep -qF "Simulation finished: PASS" \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

/* testbench/decode_tb.sv */
// Decode stage testbench

`timescale 1ns/1ps
`default_nettype none

module decode_tb import decode_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES = 2000;
    // Stimulus length plus reset and some margin
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;
    localparam logic [31:0] LFSR_SEED = 32'd21;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clk;
    logic rst;
    logic fb_valid;
    logic [XLEN-1:0] instruction;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic rs1_conflict;
    logic rs2_conflict;
    unit_vec_t unit_ready;
    logic issue_hold;
    logic pop;
    logic branch_issue;
    logic gc_issue;
    logic gc_illegal;
    logic alu_valid;
    logic [XLEN-1:0] alu_op1;
    logic [XLEN-1:0] alu_op2;
    logic ls_valid;
    logic [XLEN-1:0] ls_address;
    logic [XLEN-1:0] ls_store_data;
    logic [2:0] ls_fn3;
    logic ls_is_load;
    logic ls_is_store;
    logic ls_store_forward;

    logic [31:0] lfsr_state;
    int cycle_count = 0;
    int pop_count;
    int illegal_count;
    unit_vec_t pending_pulses;
    logic pending_illegal;
    alu_payload_t pending_alu;
    ls_payload_t pending_ls;

    decode_stage DUT (
        .clk(clk),
        .rst(rst),
        .fb_valid(fb_valid),
        .instruction(instruction),
        .pc(pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rs1_conflict(rs1_conflict),
        .rs2_conflict(rs2_conflict),
        .unit_ready(unit_ready),
        .issue_hold(issue_hold),
        .pop(pop),
        .branch_issue(branch_issue),
        .gc_issue(gc_issue),
        .gc_illegal(gc_illegal),
        .alu_valid(alu_valid),
        .alu_op1(alu_op1),
        .alu_op2(alu_op2),
        .ls_valid(ls_valid),
        .ls_address(ls_address),
        .ls_store_data(ls_store_data),
        .ls_fn3(ls_fn3),
        .ls_is_load(ls_is_load),
        .ls_is_store(ls_is_store),
        .ls_store_forward(ls_store_forward)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Failure handling and compares
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
            fail_run("Run did not complete within the cycle limit");
    end

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_pulses(input unit_vec_t got, input unit_vec_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch unit pulses: got %h, expected %h", got, exp));
    endtask

    task automatic check_alu(input alu_payload_t got, input alu_payload_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch alu_op1/alu_op2: got %h, expected %h", got, exp));
    endtask

    task automatic check_ls(input ls_payload_t got, input ls_payload_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch ls request: got %h, expected %h", got, exp));
    endtask

    ////////////////////////////////////////
    // Random source
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ LFSR_TAPS;
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] draw_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic opcode_t pick_opcode(input logic [3:0] index);
        case (index)
            4'd0: return LUI_T;
            4'd1: return AUIPC_T;
            4'd2: return JAL_T;
            4'd3: return JALR_T;
            4'd4: return BRANCH_T;
            4'd5: return STORE_T;
            4'd6: return ARITH_T;
            4'd7: return ARITH_IMM_T;
            4'd8: return FENCE_T;
            4'd9: return SYSTEM_T;
            4'd10: return ARITH_IMM_T;
            4'd11: return STORE_T;
            default: return LOAD_T;
        endcase
    endfunction

    task automatic drive_random_inputs();
        logic [3:0] kind;
        logic [31:0] fields;
        logic [31:0] low;
        kind = 4'(draw_bits(4));
        fields = draw_bits(25);
        instruction = {fields[24:0], pick_opcode(kind), 2'b11};
        // A few fully random words, a few with broken low bits
        if (kind == 4'd14)
            instruction = draw_bits(32);
        if (kind == 4'd15) begin
            low = draw_bits(1);
            instruction[1:0] = {low[0], ~low[0]};
        end
        pc = draw_bits(30) << 2;
        rs1_data = draw_bits(32);
        rs2_data = draw_bits(32);
        fb_valid = (draw_bits(3) != 32'd0);
        issue_hold = (draw_bits(3) == 32'd0);
        rs1_conflict = (draw_bits(3) == 32'd0);
        rs2_conflict = (draw_bits(2) == 32'd0);
        for (int u = 0; u < NUM_UNITS; u++)
            unit_ready[u] = (draw_bits(2) != 32'd0);
    endtask

    ////////////////////////////////////////
    // Reference model
    function automatic logic known_opcode(input opcode_t op);
        case (op)
            LUI_T, AUIPC_T, JAL_T, JALR_T, BRANCH_T, LOAD_T, STORE_T,
            ARITH_T, ARITH_IMM_T, FENCE_T, SYSTEM_T: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Bit 25 on a register op would be multiply or divide
    function automatic logic model_illegal(input logic [XLEN-1:0] instr);
        return instr[1:0] != 2'b11 || !known_opcode(instr[6:2]) ||
            (instr[6:2] == ARITH_T && instr[25]);
    endfunction

    function automatic unit_vec_t model_request(input logic [XLEN-1:0] instr);
        unit_vec_t req;
        req = '0;
        if (model_illegal(instr)) begin
            req[GC_UNIT] = 1'b1;
        end else begin
            case (instr[6:2])
                BRANCH_T: req[BRANCH_UNIT] = 1'b1;
                JAL_T, JALR_T: begin
                    req[BRANCH_UNIT] = 1'b1;
                    req[ALU_UNIT] = 1'b1;
                end
                LOAD_T, STORE_T: req[LS_UNIT] = 1'b1;
                FENCE_T, SYSTEM_T: req[GC_UNIT] = 1'b1;
                // LUI, AUIPC and both arithmetic forms
                default: req[ALU_UNIT] = 1'b1;
            endcase
        end
        return req;
    endfunction

    function automatic alu_payload_t model_alu(input logic [XLEN-1:0] instr,
                                               input logic [XLEN-1:0] pc_in,
                                               input logic [XLEN-1:0] rs1,
                                               input logic [XLEN-1:0] rs2);
        alu_payload_t ops;
        ops.op1 = rs1;
        ops.op2 = rs2;
        case (instr[6:2])
            LUI_T: begin
                ops.op1 = '0;
                ops.op2 = {instr[31:12], 12'h000};
            end
            AUIPC_T: begin
                ops.op1 = pc_in;
                ops.op2 = {instr[31:12], 12'h000};
            end
            JAL_T, JALR_T: begin
                ops.op1 = pc_in;
                ops.op2 = 32'd4;
            end
            ARITH_IMM_T: ops.op2 = {{20{instr[31]}}, instr[31:20]};
            default: ;
        endcase
        return ops;
    endfunction

    function automatic ls_payload_t model_ls(input logic [XLEN-1:0] instr,
                                             input logic [XLEN-1:0] rs1,
                                             input logic [XLEN-1:0] rs2,
                                             input logic rs2_busy);
        ls_payload_t req;
        logic [11:0] offset;
        logic store;
        store = !model_illegal(instr) && instr[6:2] == STORE_T;
        offset = store ? {instr[31:25], instr[11:7]} : instr[31:20];
        req.address = rs1 + {{20{offset[11]}}, offset};
        req.store_data = rs2;
        req.fn3 = instr[14:12];
        req.is_load = !model_illegal(instr) && instr[6:2] == LOAD_T;
        req.is_store = store;
        req.store_forward = store && rs2_busy;
        return req;
    endfunction

    ////////////////////////////////////////
    // Observed outputs
    function automatic unit_vec_t observed_pulses();
        unit_vec_t pulses;
        pulses[BRANCH_UNIT] = branch_issue;
        pulses[ALU_UNIT] = alu_valid;
        pulses[LS_UNIT] = ls_valid;
        pulses[GC_UNIT] = gc_issue;
        return pulses;
    endfunction

    function automatic alu_payload_t observed_alu();
        alu_payload_t ops;
        ops.op1 = alu_op1;
        ops.op2 = alu_op2;
        return ops;
    endfunction

    function automatic ls_payload_t observed_ls();
        ls_payload_t req;
        req.address = ls_address;
        req.store_data = ls_store_data;
        req.fn3 = ls_fn3;
        req.is_load = ls_is_load;
        req.is_store = ls_is_store;
        req.store_forward = ls_store_forward;
        return req;
    endfunction

    // Registered results of the last cycle, then this cycle's pop
    task automatic check_cycle();
        unit_vec_t request;
        logic store;
        logic expected_pop;
        check_pulses(observed_pulses(), pending_pulses);
        check_flag("gc_illegal", gc_illegal, pending_illegal);
        if (pending_pulses[ALU_UNIT])
            check_alu(observed_alu(), pending_alu);
        if (pending_pulses[LS_UNIT])
            check_ls(observed_ls(), pending_ls);

        request = model_request(instruction);
        store = request[LS_UNIT] && instruction[6:2] == STORE_T;
        expected_pop = fb_valid && !issue_hold && !rs1_conflict &&
            (!rs2_conflict || store) && ((request & ~unit_ready) == '0);
        check_flag("pop", pop, expected_pop);

        pending_pulses = expected_pop ? request : '0;
        pending_illegal = expected_pop && model_illegal(instruction);
        pending_alu = model_alu(instruction, pc, rs1_data, rs2_data);
        pending_ls = model_ls(instruction, rs1_data, rs2_data, rs2_conflict);
        if (expected_pop)
            pop_count++;
        if (pending_illegal)
            illegal_count++;
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        fb_valid = 1'b0;
        instruction = '0;
        pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        unit_ready = '0;
        issue_hold = 1'b0;
        lfsr_state = LFSR_SEED;
        pop_count = 0;
        illegal_count = 0;
        pending_pulses = '0;
        pending_illegal = 1'b0;
        pending_alu = '0;
        pending_ls = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        // Nothing may be pending straight out of reset
        @(negedge clk);
        check_pulses(observed_pulses(), '0);
        check_flag("gc_illegal", gc_illegal, 1'b0);

        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_random_inputs();
            @(negedge clk);
            check_cycle();
        end

        if (pop_count == 0 || illegal_count == 0) begin
            fail_run("Stimulus never issued an instruction or never issued an illegal word");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
